/* hw/rv64_defs.svh */
`ifndef RV64_DEFS_SVH
`define RV64_DEFS_SVH

// datapath widths
`define XLEN      64
`define ILEN      32      // instruction word
`define SHAMT_W   6       // 64-bit shifts
`define SHAMT_W32 5       // register forms of the word shifts

// major opcodes handled by the execute block
`define OPC_OP        7'b0110011
`define OPC_OP_IMM    7'b0010011
`define OPC_OP_32     7'b0111011
`define OPC_OP_IMM_32 7'b0011011
`define OPC_JAL       7'b1101111
`define OPC_JALR      7'b1100111

`endif

/* hw/rv64_pkg.sv */
`include "rv64_defs.svh"

package rv64_pkg;

	typedef logic [`ILEN-1:0] u32;
	typedef logic [`XLEN-1:0] u64;

	typedef enum logic [4:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_S_LESS,      // slt
		ALU_U_LESS,      // sltu
		ALU_L_SL,
		ALU_L_SR,
		ALU_A_SR,
		// word forms, register amount
		ALU_ADDW,
		ALU_SUBW,
		ALU_L_SLW,
		ALU_L_SRW,
		ALU_A_SRW,
		// word forms, immediate amount
		ALU_ADDIW,
		ALU_L_SLIW,
		ALU_L_SRIW,
		ALU_A_SRIW,
		ALU_B,           // branch compare path, never selected here
		ALU_LINK,        // passes operand b
		ALU_RS1_ADD_0,   // passes rs1
		ALU_CSRRC
	} alufunc_t;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_type_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_type_t;

	// same word, two field layouts
	typedef union packed {
		r_type_t r;
		i_type_t i;
	} instr_u;

	typedef enum logic [1:0] {
		OPB_RS2,
		OPB_IMM,
		OPB_PC_PLUS4
	} opb_sel_t;

endpackage

/* hw/alu.sv */
`timescale 1ns/1ps
`include "rv64_defs.svh"

module alu
	import rv64_pkg::*;
(
	input  logic     clk,      // only for the check below
	input  u64       rd1,
	input  u64       rd2,
	input  alufunc_t ALUOP,
	output u64       ALU_out
);

	u64 result;
	u32 result_32;

	// sign-extend a 32-bit word result to XLEN
	function automatic u64 sext_w(input u32 v);
		return {{(`XLEN-32){v[31]}}, v};
	endfunction

	always_comb begin
		result    = '0;
		result_32 = '0;
		ALU_out   = '0;
		unique case (ALUOP)
			ALU_ADD:    ALU_out = rd1 + rd2;
			ALU_SUB:    ALU_out = rd1 - rd2;
			ALU_AND:    ALU_out = rd1 & rd2;
			ALU_OR:     ALU_out = rd1 | rd2;
			ALU_XOR:    ALU_out = rd1 ^ rd2;
			ALU_S_LESS: begin
				ALU_out = {{(`XLEN-1){1'b0}}, $signed(rd1) < $signed(rd2)};
			end
			ALU_U_LESS: begin
				ALU_out = {{(`XLEN-1){1'b0}}, rd1 < rd2};
			end
			ALU_L_SL:   ALU_out = rd1 << rd2[`SHAMT_W-1:0];
			ALU_L_SR:   ALU_out = rd1 >> rd2[`SHAMT_W-1:0];
			ALU_A_SR:   ALU_out = $signed(rd1) >>> rd2[`SHAMT_W-1:0];
			ALU_ADDW: begin
				result  = rd1 + rd2;
				ALU_out = sext_w(result[31:0]);
			end
			ALU_SUBW: begin
				result  = rd1 - rd2;
				ALU_out = sext_w(result[31:0]);
			end
			ALU_L_SLW: begin
				result_32 = rd1[31:0] << rd2[`SHAMT_W32-1:0];
				ALU_out   = sext_w(result_32);
			end
			ALU_L_SRW: begin
				result_32 = rd1[31:0] >> rd2[`SHAMT_W32-1:0];
				ALU_out   = sext_w(result_32);
			end
			ALU_A_SRW: begin
				// low word is shifted before widening
				result_32 = $signed(rd1[31:0]) >>> rd2[`SHAMT_W32-1:0];
				ALU_out   = sext_w(result_32);
			end
			ALU_ADDIW: begin
				result  = rd1 + rd2;
				ALU_out = sext_w(result[31:0]);
			end
			ALU_L_SLIW: begin
				result  = rd1 << rd2[`SHAMT_W-1:0];
				ALU_out = sext_w(result[31:0]);
			end
			ALU_L_SRIW: begin
				result_32 = rd1[31:0] >> rd2[`SHAMT_W-1:0];
				ALU_out   = sext_w(result_32);
			end
			ALU_A_SRIW: begin
				result_32 = $signed(rd1[31:0]) >>> rd2[`SHAMT_W-1:0];
				ALU_out   = sext_w(result_32);
			end
			ALU_B:         ALU_out = '0;   // compare lives in the branch unit
			ALU_LINK:      ALU_out = rd2;
			ALU_RS1_ADD_0: ALU_out = rd1;
			ALU_CSRRC: begin
				// clear mask applied to the low field only
				ALU_out = (rd2 & ~rd1) & `XLEN'h0f;
			end
			default:       ALU_out = '0;
		endcase
	end

	// decoder must always hand over a defined function
	a_aluop_known: assert property (@(posedge clk) !$isunknown(ALUOP))
		else $error("alu: function select is unknown");

endmodule

/* hw/alu_decoder.sv */
`timescale 1ns/1ps
`include "rv64_defs.svh"

module alu_decoder
	import rv64_pkg::*;
(
	input  instr_u   instr,
	input  u64       rs2_val,
	input  u64       pc,
	output alufunc_t alu_op,
	output u64       op_b,
	output logic     illegal
);

	opb_sel_t   sel;
	logic [6:0] f7;
	logic [2:0] f3;
	logic       alt;      // bit 30 picks sub / sra
	logic       f7_ok;

	assign f7  = instr.r.funct7;
	assign f3  = instr.r.funct3;
	assign alt = instr.r.funct7[5];

	// 0x20 is only meaningful for add/sub and the right shifts
	assign f7_ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));

	always_comb begin
		alu_op  = ALU_LINK;
		sel     = OPB_RS2;
		illegal = 1'b0;
		case (instr.r.opcode)
			`OPC_OP: begin
				illegal = !f7_ok;
				case (f3)
					3'b000: alu_op = alt ? ALU_SUB : ALU_ADD;
					3'b001: alu_op = ALU_L_SL;
					3'b010: alu_op = ALU_S_LESS;
					3'b011: alu_op = ALU_U_LESS;
					3'b100: alu_op = ALU_XOR;
					3'b101: alu_op = alt ? ALU_A_SR : ALU_L_SR;
					3'b110: alu_op = ALU_OR;
					default: alu_op = ALU_AND;
				endcase
			end
			`OPC_OP_IMM: begin
				sel = OPB_IMM;
				case (f3)
					3'b000: alu_op = ALU_ADD;
					3'b010: alu_op = ALU_S_LESS;
					3'b011: alu_op = ALU_U_LESS;
					3'b100: alu_op = ALU_XOR;
					3'b110: alu_op = ALU_OR;
					3'b111: alu_op = ALU_AND;
					3'b001: begin
						alu_op  = ALU_L_SL;
						illegal = instr.i.imm[11:6] != 6'h00;
					end
					default: begin   // srli / srai
						alu_op  = alt ? ALU_A_SR : ALU_L_SR;
						illegal = instr.i.imm[11:6] != 6'h00 && instr.i.imm[11:6] != 6'h10;
					end
				endcase
			end
			`OPC_OP_32: begin
				illegal = !f7_ok;
				case (f3)
					3'b000: alu_op = alt ? ALU_SUBW : ALU_ADDW;
					3'b001: alu_op = ALU_L_SLW;
					3'b101: alu_op = alt ? ALU_A_SRW : ALU_L_SRW;
					default: illegal = 1'b1;
				endcase
			end
			`OPC_OP_IMM_32: begin
				sel = OPB_IMM;
				case (f3)
					3'b000: alu_op = ALU_ADDIW;
					3'b001: begin
						alu_op  = ALU_L_SLIW;
						illegal = f7 != 7'h00;       // also catches bit 25
					end
					3'b101: begin
						alu_op  = alt ? ALU_A_SRIW : ALU_L_SRIW;
						illegal = !f7_ok;
					end
					default: illegal = 1'b1;
				endcase
			end
			`OPC_JAL, `OPC_JALR: sel = OPB_PC_PLUS4;   // link value
			default: illegal = 1'b1;
		endcase
		if (illegal) begin
			alu_op = ALU_LINK;
			sel    = OPB_RS2;
		end
	end

	always_comb begin
		case (sel)
			OPB_IMM:      op_b = {{(`XLEN-12){instr.i.imm[11]}}, instr.i.imm};
			OPB_PC_PLUS4: op_b = pc + `XLEN'd4;
			default:      op_b = rs2_val;
		endcase
	end

endmodule

/* hw/exec_ctrl.sv */
`timescale 1ns/1ps

module exec_ctrl
	import rv64_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   req,
	input  u32     instr,
	input  u64     rs1_val,
	input  u64     rs2_val,
	input  u64     pc,
	input  u64     alu_result,
	input  logic   dec_illegal,
	output logic   ack,
	output u64     result,
	output logic   illegal,
	output instr_u q_instr,
	output u64     q_rs1,
	output u64     q_rs2,
	output u64     q_pc
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_EXEC,
		S_DONE
	} state_t;

	state_t state;

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= S_IDLE;
			ack     <= 1'b0;
			result  <= '0;
			illegal <= 1'b0;
		end else begin
			case (state)
				S_IDLE: if (req) state <= S_EXEC;
				S_EXEC: begin
					result  <= dec_illegal ? '0 : alu_result;   // zero on illegal
					illegal <= dec_illegal;
					ack     <= 1'b1;
					state   <= S_DONE;
				end
				S_DONE: begin
					if (!req) begin      // hold ack while req stays up
						ack   <= 1'b0;
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// request capture
	always_ff @(posedge clk) begin
		if (state == S_IDLE && req) begin
			q_instr <= instr;
			q_rs1   <= rs1_val;
			q_rs2   <= rs2_val;
			q_pc    <= pc;
		end
	end

	a_ack_from_exec: assert property (@(posedge clk) disable iff (reset)
		$rose(ack) |-> $past(state) == S_EXEC);

	a_req_held: assert property (@(posedge clk) disable iff (reset)
		state == S_EXEC |-> req)
		else $error("exec_ctrl: req dropped before ack");

	a_ack_after_req: assert property (@(posedge clk) disable iff (reset)
		$fell(ack) |-> !$past(req));

endmodule

/* hw/exec_top.sv */
`timescale 1ns/1ps

module exec_top
	import rv64_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic req,
	input  u32   instr,
	input  u64   rs1_val,
	input  u64   rs2_val,
	input  u64   pc,
	output logic ack,
	output u64   result,
	output logic illegal
);

	instr_u   q_instr;
	u64       q_rs1;
	u64       q_rs2;
	u64       q_pc;
	alufunc_t alu_op;
	u64       op_b;
	u64       alu_out;
	logic     dec_illegal;

	exec_ctrl ctrl_i (
		.clk         (clk),
		.reset       (reset),
		.req         (req),
		.instr       (instr),
		.rs1_val     (rs1_val),
		.rs2_val     (rs2_val),
		.pc          (pc),
		.alu_result  (alu_out),
		.dec_illegal (dec_illegal),
		.ack         (ack),
		.result      (result),
		.illegal     (illegal),
		.q_instr     (q_instr),
		.q_rs1       (q_rs1),
		.q_rs2       (q_rs2),
		.q_pc        (q_pc)
	);

	alu_decoder dec_i (
		.instr   (q_instr),
		.rs2_val (q_rs2),
		.pc      (q_pc),
		.alu_op  (alu_op),
		.op_b    (op_b),
		.illegal (dec_illegal)
	);

	alu alu_i (
		.clk     (clk),
		.rd1     (q_rs1),
		.rd2     (op_b),
		.ALUOP   (alu_op),
		.ALU_out (alu_out)
	);

endmodule

/* tests/exec_checker.sv */
`timescale 1ns/1ps
`include "rv64_defs.svh"

module exec_checker
	import rv64_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic req,
	input  u32   instr,
	input  u64   rs1_val,
	input  u64   rs2_val,
	input  u64   pc,
	input  logic ack,
	input  u64   result,
	input  logic illegal,
	input  logic row_check,     // tb supplies expected values for this request
	input  u64   row_result,
	input  logic row_illegal,
	output int   value_errors,
	output int   proto_errors
);

	logic req_q;
	logic ack_q;
	logic busy;          // request accepted and ack not yet dropped
	int   wait_cnt;
	int   low_cnt;
	u64   exp_res;
	logic exp_ill;

	// reference model of decoder plus ALU
	task automatic model_exec(input u32 ins, input u64 a, input u64 b, input u64 p,
			output u64 res, output logic ill);
		logic [6:0] opc;
		logic [6:0] f7;
		logic [2:0] f3;
		u64         imm;
		logic [5:0] sh;
		logic [31:0] w;
		opc = ins[6:0];
		f3  = ins[14:12];
		f7  = ins[31:25];
		imm = {{52{ins[31]}}, ins[31:20]};
		sh  = ins[25:20];
		ill = 1'b0;
		res = '0;
		w   = '0;
		case (opc)
			`OPC_OP: begin
				if (!(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)))) ill = 1'b1;
				case (f3)
					3'd0: res = f7[5] ? a - b : a + b;
					3'd1: res = a << b[5:0];
					3'd2: res = {63'b0, $signed(a) < $signed(b)};
					3'd3: res = {63'b0, a < b};
					3'd4: res = a ^ b;
					3'd5: if (f7[5]) res = $signed(a) >>> b[5:0]; else res = a >> b[5:0];
					3'd6: res = a | b;
					default: res = a & b;
				endcase
			end
			`OPC_OP_IMM: begin
				case (f3)
					3'd0: res = a + imm;
					3'd2: res = {63'b0, $signed(a) < $signed(imm)};
					3'd3: res = {63'b0, a < imm};
					3'd4: res = a ^ imm;
					3'd6: res = a | imm;
					3'd7: res = a & imm;
					3'd1: if (ins[31:26] != 6'h00) ill = 1'b1; else res = a << sh;
					default: begin
						if (ins[31:26] == 6'h00) res = a >> sh;
						else if (ins[31:26] == 6'h10) res = $signed(a) >>> sh;
						else ill = 1'b1;
					end
				endcase
			end
			`OPC_OP_32, `OPC_OP_IMM_32: begin
				// word-immediate amount is 5 bits when legal
				if (opc == `OPC_OP_IMM_32) b = imm;
				if (!(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)))) ill = 1'b1;
				if (opc == `OPC_OP_IMM_32 && f3 == 3'd0) ill = 1'b0;   // addiw ignores funct7
				if (opc == `OPC_OP_IMM_32 && f3 == 3'd0) w = a[31:0] + b[31:0];
				else if (f3 == 3'd0) w = f7[5] ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
				else if (f3 == 3'd1) w = a[31:0] << b[4:0];
				else if (f3 == 3'd5 && f7[5]) w = $signed(a[31:0]) >>> b[4:0];
				else if (f3 == 3'd5) w = a[31:0] >> b[4:0];
				else ill = 1'b1;
				res = {{32{w[31]}}, w};
			end
			`OPC_JAL, `OPC_JALR: res = p + 64'd4;
			default: ill = 1'b1;
		endcase
		if (ill) res = '0;
	endtask

	always @(posedge clk) begin
		if (reset) begin
			req_q <= 1'b0;
			ack_q <= 1'b0;
			busy  <= 1'b0;
			value_errors <= 0;
			proto_errors <= 0;
		end else begin
			req_q <= req;
			ack_q <= ack;
			if (req && !req_q && !busy) begin
				model_exec(instr, rs1_val, rs2_val, pc, exp_res, exp_ill);
				busy     <= 1'b1;
				wait_cnt <= 0;
				low_cnt  <= 0;
				if (row_check && (exp_res !== row_result || exp_ill !== row_illegal)) begin
					$display("[FAIL] %0t model result: expected %h/%b, got %h/%b",
						$time, row_result, row_illegal, exp_res, exp_ill);
					value_errors <= value_errors + 1;
				end
			end
			if (ack && !busy) begin
				$display("%0t: ack is high but no request was raised", $time);
				proto_errors <= proto_errors + 1;
			end
			if (busy && !ack) wait_cnt <= wait_cnt + 1;
			if (ack && !ack_q && busy) begin
				if (wait_cnt + 1 != 2) begin
					$display("%0t: ack rose %0d edges after req", $time, wait_cnt + 1);
					proto_errors <= proto_errors + 1;
				end
				if (result !== exp_res) begin
					$display("[FAIL] %0t result: expected %h, got %h", $time, exp_res, result);
					value_errors <= value_errors + 1;
				end
				if (illegal !== exp_ill) begin
					$display("[FAIL] %0t illegal: expected %b, got %b", $time, exp_ill, illegal);
					value_errors <= value_errors + 1;
				end
			end
			if (busy && ack && !req) begin
				low_cnt <= low_cnt + 1;
				if (low_cnt + 1 == 3) begin
					$display("%0t: ack did not fall within 2 cycles of req falling", $time);
					proto_errors <= proto_errors + 1;
				end
			end
			// ack has to stay up for as long as req is held
			if (busy && !ack && ack_q && req_q) begin
				$display("%0t: ack fell while req was still high", $time);
				proto_errors <= proto_errors + 1;
			end
			if (busy && !ack && ack_q) busy <= 1'b0;
		end
	end

endmodule

/* tests/tb_exec_top.sv */
`timescale 1ns/1ps
`include "rv64_defs.svh"

module tb_exec_top;
	import rv64_pkg::*;

	logic clk = 1'b0;
	logic reset;
	logic req;
	u32   instr;
	u64   rs1_val, rs2_val, pc;
	logic ack, illegal;
	u64   result;
	logic row_check;
	u64   row_result;
	logic row_illegal;
	int   value_errors, proto_errors;
	int   cycles = 0;
	int   limit = 0;
	u32   t_ins[$];
	u64   t_a[$], t_b[$], t_pc[$], t_res[$];
	logic t_ill[$];

	exec_top dut_i (.clk(clk), .reset(reset), .req(req), .instr(instr), .rs1_val(rs1_val),
		.rs2_val(rs2_val), .pc(pc), .ack(ack), .result(result), .illegal(illegal));

	exec_checker chk_i (.clk(clk), .reset(reset), .req(req), .instr(instr), .rs1_val(rs1_val),
		.rs2_val(rs2_val), .pc(pc), .ack(ack), .result(result), .illegal(illegal),
		.row_check(row_check), .row_result(row_result), .row_illegal(row_illegal),
		.value_errors(value_errors), .proto_errors(proto_errors));

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit != 0 && cycles > limit) begin
			$display("timeout: no finish after %0d cycles", cycles);
			$display("Simulation FAILED");
			$finish;
		end
	end

	function automatic u32 r_word(input logic [6:0] f7, input logic [2:0] f3,
			input logic [6:0] opc);
		return {f7, 5'd2, 5'd1, f3, 5'd3, opc};
	endfunction

	function automatic u32 i_word(input logic [11:0] imm, input logic [2:0] f3,
			input logic [6:0] opc);
		return {imm, 5'd1, f3, 5'd3, opc};
	endfunction

	task automatic add_row(input u32 ins, input u64 a, input u64 b, input u64 p, input u64 r,
			input logic ill);
		t_ins.push_back(ins);
		t_a.push_back(a);
		t_b.push_back(b);
		t_pc.push_back(p);
		t_res.push_back(r);
		t_ill.push_back(ill);
	endtask

	// one full four-phase transfer
	task automatic run_request(input u32 ins, input u64 a, input u64 b, input u64 p,
			input logic chk, input u64 r, input logic ill);
		@(negedge clk);
		instr = ins;
		rs1_val = a;
		rs2_val = b;
		pc = p;
		row_check = chk;
		row_result = r;
		row_illegal = ill;
		req = 1'b1;
		while (!ack) @(negedge clk);
		repeat ($urandom % 3) @(negedge clk);   // ack must stay up meanwhile
		req = 1'b0;
		while (ack) @(negedge clk);
	endtask

	task automatic random_row(output u32 ins);
		logic [2:0] f3;
		logic [5:0] sh;
		f3 = $urandom;
		sh = $urandom;
		case ($urandom % 7)
			0: ins = r_word(((f3 == 0 || f3 == 5) && $urandom % 2) ? 7'h20 : 7'h00, f3, `OPC_OP);
			1: ins = i_word($urandom, (f3 == 1 || f3 == 5) ? 3'd0 : f3, `OPC_OP_IMM);
			2: ins = i_word({(!f3[0] && $urandom % 2) ? 6'h10 : 6'h00, sh},
				f3[0] ? 3'd1 : 3'd5, `OPC_OP_IMM);
			3: ins = r_word((!f3[1] && $urandom % 2) ? 7'h20 : 7'h00,
				f3[1] ? 3'd1 : {f3[0], 1'b0, f3[0]}, `OPC_OP_32);
			4: ins = i_word($urandom, 3'd0, `OPC_OP_IMM_32);
			5: ins = i_word({1'b0, f3[0] & f3[1], 5'b0, sh[4:0]}, {f3[1], 1'b0, 1'b1},
				`OPC_OP_IMM_32);
			default: ins = i_word($urandom, 3'd0, f3[0] ? `OPC_JAL : `OPC_JALR);
		endcase
	endtask

	initial begin
		u32 ins;
		void'($urandom(32'h1a0a_e3e4));
		reset = 1'b1;
		req = 1'b0;
		instr = '0;
		rs1_val = '0;
		rs2_val = '0;
		pc = '0;
		row_check = 1'b0;
		row_result = '0;
		row_illegal = 1'b0;
		add_row(r_word(7'h00, 3'd0, `OPC_OP), 64'd5, 64'd7, 0, 64'd12, 0);
		add_row(r_word(7'h20, 3'd0, `OPC_OP), 64'd5, 64'd7, 0, 64'hffff_ffff_ffff_fffe, 0);
		add_row(r_word(7'h00, 3'd7, `OPC_OP), 64'hff00_ff00_ff00_ff00, 64'h0ff0_0ff0_0ff0_0ff0, 0,
			64'h0f00_0f00_0f00_0f00, 0);
		add_row(r_word(7'h00, 3'd6, `OPC_OP), 64'hff00_ff00_ff00_ff00, 64'h0ff0_0ff0_0ff0_0ff0, 0,
			64'hfff0_fff0_fff0_fff0, 0);
		add_row(r_word(7'h00, 3'd4, `OPC_OP), 64'hff00_ff00_ff00_ff00, 64'h0ff0_0ff0_0ff0_0ff0, 0,
			64'hf0f0_f0f0_f0f0_f0f0, 0);
		add_row(r_word(7'h00, 3'd2, `OPC_OP), 64'h8000_0000_0000_0000, 64'd1, 0, 64'd1, 0);
		add_row(r_word(7'h00, 3'd3, `OPC_OP), 64'h8000_0000_0000_0000, 64'd1, 0, 64'd0, 0);
		add_row(r_word(7'h00, 3'd1, `OPC_OP), 64'd1, 64'h43, 0, 64'd8, 0);   // low 6 bits only
		add_row(r_word(7'h00, 3'd5, `OPC_OP), 64'h8000_0000_0000_0000, 64'd63, 0, 64'd1, 0);
		add_row(r_word(7'h20, 3'd5, `OPC_OP), 64'h8000_0000_0000_0000, 64'd4, 0,
			64'hf800_0000_0000_0000, 0);
		add_row(r_word(7'h00, 3'd1, `OPC_OP_32), 64'd1, 64'd31, 0,
			64'hffff_ffff_8000_0000, 0);
		add_row(r_word(7'h00, 3'd5, `OPC_OP_32), 64'hffff_ffff_8000_0000, 64'd4, 0,
			64'h0800_0000, 0);
		add_row(r_word(7'h20, 3'd5, `OPC_OP_32), 64'h8000_0000, 64'd4, 0,
			64'hffff_ffff_f800_0000, 0);
		add_row(r_word(7'h00, 3'd0, `OPC_OP_32), 64'hffff_ffff, 64'd1, 0, 64'd0, 0);
		add_row(i_word(12'hfff, 3'd0, `OPC_OP_IMM), 64'd10, 0, 0, 64'd9, 0);
		add_row(i_word(12'h001, 3'd0, `OPC_OP_IMM_32), 64'h7fff_ffff, 0, 0,
			64'hffff_ffff_8000_0000, 0);
		add_row(i_word(12'h408, 3'd5, `OPC_OP_IMM), 64'h8000_0000_0000_0000, 0, 0,
			64'hff80_0000_0000_0000, 0);
		add_row(i_word(12'h008, 3'd5, `OPC_OP_IMM), 64'h8000_0000_0000_0000, 0, 0,
			64'h0080_0000_0000_0000, 0);
		add_row(i_word(12'h404, 3'd5, `OPC_OP_IMM_32), 64'h8000_0000, 0, 0,
			64'hffff_ffff_f800_0000, 0);
		add_row(i_word(12'h004, 3'd5, `OPC_OP_IMM_32), 64'h8000_0000, 0, 0, 64'h0800_0000, 0);
		add_row(i_word(12'h800, 3'd2, `OPC_OP_IMM), 64'd1, 0, 0, 64'd0, 0);
		add_row(i_word(12'hfff, 3'd3, `OPC_OP_IMM), 64'd5, 0, 0, 64'd1, 0);
		add_row(i_word(12'hfff, 3'd4, `OPC_OP_IMM), 64'hff, 0, 0, 64'hffff_ffff_ffff_ff00, 0);
		add_row(i_word(12'h123, 3'd0, `OPC_JAL), 64'd77, 64'd88, 64'h1000, 64'h1004, 0);
		add_row(i_word(12'h000, 3'd0, `OPC_JALR), 64'd1, 64'd2, 64'hffff_ffff_ffff_fffc, 64'd0, 0);
		add_row(r_word(7'h01, 3'd0, `OPC_OP), 64'd5, 64'd7, 0, 64'd0, 1);        // bad funct7
		add_row(i_word(12'h000, 3'd0, 7'b0000011), 64'd5, 64'd7, 0, 64'd0, 1);   // load opcode
		add_row(i_word(12'h021, 3'd1, `OPC_OP_IMM_32), 64'd5, 64'd7, 0, 64'd0, 1);  // bit 25
		limit = (t_ins.size() + 200) * 8 + 100;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		foreach (t_ins[i])
			run_request(t_ins[i], t_a[i], t_b[i], t_pc[i], 1'b1, t_res[i], t_ill[i]);
		repeat (200) begin
			random_row(ins);
			run_request(ins, {$urandom, $urandom}, {$urandom, $urandom}, {$urandom, $urandom},
				1'b0, '0, 1'b0);
		end
		repeat (3) @(negedge clk);
		$display("errors: value %0d, protocol %0d", value_errors, proto_errors);
		if (value_errors == 0 && proto_errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* list.f */
+incdir+hw
hw/rv64_pkg.sv
hw/alu.sv
hw/alu_decoder.sv
hw/exec_ctrl.sv
hw/exec_top.sv
tests/exec_checker.sv
tests/tb_exec_top.sv

/* Bender.yml */
package:
  name: rv64_exec

sources:
  - include_dirs:
      - hw
    files:
      - hw/rv64_pkg.sv
      - hw/alu.sv
      - hw/alu_decoder.sv
      - hw/exec_ctrl.sv
      - hw/exec_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/exec_checker.sv
      - tests/tb_exec_top.sv
